/* design/mem2nfifo.sv */
`timescale 1ns/1ps
`default_nettype none

module mem2nfifo #(
  parameter int FLOWS      = nfifo_dim_pkg::DEF_FLOWS,
  parameter int FLOW_WIDTH = nfifo_dim_pkg::DEF_FLOW_WIDTH,
  parameter int BLOCK_SIZE = nfifo_dim_pkg::DEF_BLOCK_SIZE,
  parameter int CREDITS    = nfifo_dim_pkg::DEF_CREDITS
) (
  input  logic                                                 clk,
  input  logic                                                 rst_n,
  // ----------------------------------------------------------
  // Write side
  // ----------------------------------------------------------
  input  logic [FLOW_WIDTH-1:0]                                data_in,
  input  logic [nfifo_addr_pkg::flow_width(FLOWS)-1:0]         block_addr,
  input  logic [nfifo_addr_pkg::ptr_width(BLOCK_SIZE)-1:0]     wr_addr,
  input  logic                                                 write,
  input  logic [nfifo_addr_pkg::status_width(BLOCK_SIZE)-1:0]  new_len,
  input  logic                                                 new_len_dv,
  output logic [FLOWS-1:0]                                     full,
  output logic [FLOWS-1:0][nfifo_addr_pkg::status_width(BLOCK_SIZE)-1:0] status,
  // ----------------------------------------------------------
  // Read side, one lane per flow
  // ----------------------------------------------------------
  output logic [FLOWS-1:0][FLOW_WIDTH-1:0]                     data_out,
  output logic [FLOWS-1:0]                                     data_vld,
  input  logic [FLOWS-1:0]                                     read,
  output logic [FLOWS-1:0]                                     empty
);

  mem_wr_if #(
    .FLOWS      (FLOWS),
    .FLOW_WIDTH (FLOW_WIDTH),
    .BLOCK_SIZE (BLOCK_SIZE)
  ) u_mem_wr ();

  nfifo_credit_if #(
    .FLOWS      (FLOWS),
    .FLOW_WIDTH (FLOW_WIDTH)
  ) u_credit ();

  // Producer
  nfifo_write_ctrl #(
    .FLOWS      (FLOWS),
    .FLOW_WIDTH (FLOW_WIDTH),
    .BLOCK_SIZE (BLOCK_SIZE)
  ) u_write_ctrl (
    .clk        (clk),
    .rst_n      (rst_n),
    .data_in    (data_in),
    .block_addr (block_addr),
    .wr_addr    (wr_addr),
    .write      (write),
    .new_len    (new_len),
    .new_len_dv (new_len_dv),
    .mem        (u_mem_wr.producer)
  );

  // Shared buffer and sender
  nfifo_block_mem #(
    .FLOWS      (FLOWS),
    .FLOW_WIDTH (FLOW_WIDTH),
    .BLOCK_SIZE (BLOCK_SIZE),
    .CREDITS    (CREDITS)
  ) u_block_mem (
    .clk        (clk),
    .rst_n      (rst_n),
    .mem        (u_mem_wr.buffer),
    .xfer       (u_credit.sender),
    .full       (full),
    .status     (status)
  );

  // Consumer
  nfifo_read_port #(
    .FLOWS      (FLOWS),
    .FLOW_WIDTH (FLOW_WIDTH),
    .CREDITS    (CREDITS)
  ) u_read_port (
    .clk        (clk),
    .rst_n      (rst_n),
    .xfer       (u_credit.receiver),
    .read       (read),
    .data_out   (data_out),
    .data_vld   (data_vld),
    .empty      (empty)
  );

endmodule : mem2nfifo

`default_nettype wire

/* design/nfifo_addr_pkg.sv */
`default_nettype none

// ----------------------------------------------------------
// Width and address helpers for the shared block memory
// ----------------------------------------------------------
package nfifo_addr_pkg;

  // Offset bits inside one block, never below one
  function automatic int ptr_width(input int block_size);
    return (block_size > 1) ? $clog2(block_size) : 1;
  endfunction

  // Counts 0 through block_size inclusive
  function automatic int status_width(input int block_size);
    return $clog2(block_size + 1);
  endfunction

  // Flow index bits
  function automatic int flow_width(input int flows);
    return (flows > 1) ? $clog2(flows) : 1;
  endfunction

  // Whole shared memory address
  function automatic int phys_width(input int flows, input int block_size);
    return (flows * block_size > 1) ? $clog2(flows * block_size) : 1;
  endfunction

  // Blocks are laid out back to back, flow 0 first
  function automatic int block_base(input int flow, input int block_size);
    return flow * block_size;
  endfunction

endpackage : nfifo_addr_pkg

`default_nettype wire

/* design/nfifo_block_mem.sv */
`timescale 1ns/1ps
`default_nettype none

module nfifo_block_mem #(
  parameter int FLOWS      = nfifo_dim_pkg::DEF_FLOWS,
  parameter int FLOW_WIDTH = nfifo_dim_pkg::DEF_FLOW_WIDTH,
  parameter int BLOCK_SIZE = nfifo_dim_pkg::DEF_BLOCK_SIZE,
  parameter int CREDITS    = nfifo_dim_pkg::DEF_CREDITS
) (
  input  logic                  clk,
  input  logic                  rst_n,
  mem_wr_if.buffer              mem,
  nfifo_credit_if.sender        xfer,
  output logic [FLOWS-1:0]      full,
  output logic [FLOWS-1:0][nfifo_addr_pkg::status_width(BLOCK_SIZE)-1:0] status
);
  localparam int PW  = nfifo_addr_pkg::ptr_width(BLOCK_SIZE);
  localparam int SW  = nfifo_addr_pkg::status_width(BLOCK_SIZE);
  localparam int FW  = nfifo_addr_pkg::flow_width(FLOWS);
  localparam int PHW = nfifo_addr_pkg::phys_width(FLOWS, BLOCK_SIZE);
  localparam int CW  = $clog2(CREDITS + 1);

  // Shared storage, one block per flow
  logic [FLOW_WIDTH-1:0] ram [FLOWS*BLOCK_SIZE];

  // Per-flow state
  logic [PW-1:0]         rd_ptr [FLOWS];
  logic [SW-1:0]         pend   [FLOWS];  // committed, not yet sent
  logic [SW-1:0]         occ    [FLOWS];  // committed, not yet popped
  logic [CW-1:0]         cred   [FLOWS];
  logic [SW-1:0]         commit_add [FLOWS];

  // Arbiter
  logic [FW-1:0]         rr_last;
  logic [FLOWS-1:0]      eligible;
  logic [FLOWS-1:0]      take;
  logic                  sel_vld;
  logic [FW-1:0]         sel;
  logic [PHW-1:0]        rd_addr;

  // Transfer stage
  logic                  xfer_vld_q;
  logic [FW-1:0]         xfer_flow_q;
  logic [FLOW_WIDTH-1:0] xfer_data_q;

  always_comb begin
    for (int f = 0; f < FLOWS; f++) begin
      // Needs a word to send and room downstream
      eligible[f] = (pend[f] != '0) && (cred[f] != '0);
      if (mem.commit_vld && (mem.commit_flow == FW'(f))) begin
        commit_add[f] = mem.commit_len;
      end else begin
        commit_add[f] = '0;
      end
    end
  end

  // ----------------------------------------------------------
  // Round-robin pick, search starts after the last winner
  // ----------------------------------------------------------
  always_comb begin
    int idx;
    sel_vld = 1'b0;
    sel     = '0;
    for (int i = 1; i <= FLOWS; i++) begin
      idx = (int'(rr_last) + i) % FLOWS;
      if (!sel_vld && eligible[idx]) begin
        sel_vld = 1'b1;
        sel     = FW'(idx);
      end
    end
  end

  always_comb begin
    for (int f = 0; f < FLOWS; f++) begin
      take[f] = sel_vld && (sel == FW'(f));
    end
    rd_addr = PHW'(nfifo_addr_pkg::block_base(int'(sel), BLOCK_SIZE)) + PHW'(rd_ptr[sel]);
  end

  // ----------------------------------------------------------
  // Counters and pointers
  // ----------------------------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int f = 0; f < FLOWS; f++) begin
        rd_ptr[f] <= '0;
        pend[f]   <= '0;
        occ[f]    <= '0;
        cred[f]   <= CW'(CREDITS);
      end
      // Flow 0 wins first
      rr_last    <= FW'(FLOWS - 1);
      xfer_vld_q <= 1'b0;
    end else begin
      xfer_vld_q <= sel_vld;
      if (sel_vld) begin
        rr_last <= sel;
      end
      for (int f = 0; f < FLOWS; f++) begin
        // Credit is spent at selection, not at delivery
        pend[f] <= pend[f] + commit_add[f] - SW'(take[f]);
        cred[f] <= cred[f] + CW'(xfer.credit_ret[f]) - CW'(take[f]);
        // Word leaves the count only once a reader pops it
        occ[f]  <= occ[f] + commit_add[f] - SW'(xfer.credit_ret[f]);
        if (take[f]) begin
          rd_ptr[f] <= (rd_ptr[f] == PW'(BLOCK_SIZE - 1)) ? '0 : rd_ptr[f] + 1'b1;
        end
      end
    end
  end

  // Memory and read data register
  always_ff @(posedge clk) begin
    if (mem.wr_en) begin
      ram[mem.wr_addr] <= mem.wr_data;
    end
    if (sel_vld) begin
      xfer_data_q <= ram[rd_addr];
      xfer_flow_q <= sel;
    end
  end

  always_comb begin
    for (int f = 0; f < FLOWS; f++) begin
      status[f] = occ[f];
      full[f]   = (occ[f] == SW'(BLOCK_SIZE));
    end
  end

  assign xfer.xfer_vld  = xfer_vld_q;
  assign xfer.xfer_flow = xfer_flow_q;
  assign xfer.xfer_data = xfer_data_q;

endmodule : nfifo_block_mem

`default_nettype wire

/* design/nfifo_dim_pkg.sv */
`default_nettype none

// ----------------------------------------------------------
// Default dimensions of the multi-flow FIFO
// ----------------------------------------------------------
package nfifo_dim_pkg;

  // Number of independent flows
  localparam int DEF_FLOWS = 4;

  // Bits per word of a single flow
  localparam int DEF_FLOW_WIDTH = 16;

  // Words per flow block in the shared memory
  localparam int DEF_BLOCK_SIZE = 16;

  // Output FIFO depth per flow, also the initial credit count
  localparam int DEF_CREDITS = 2;

endpackage : nfifo_dim_pkg

`default_nettype wire

/* design/nfifo_if.sv */
`timescale 1ns/1ps
`default_nettype none

// ----------------------------------------------------------
// Producer to buffer, memory writes and commits
// ----------------------------------------------------------
interface mem_wr_if #(
  parameter int FLOWS      = nfifo_dim_pkg::DEF_FLOWS,
  parameter int FLOW_WIDTH = nfifo_dim_pkg::DEF_FLOW_WIDTH,
  parameter int BLOCK_SIZE = nfifo_dim_pkg::DEF_BLOCK_SIZE
);
  localparam int PHW = nfifo_addr_pkg::phys_width(FLOWS, BLOCK_SIZE);
  localparam int FW  = nfifo_addr_pkg::flow_width(FLOWS);
  localparam int SW  = nfifo_addr_pkg::status_width(BLOCK_SIZE);

  // Physical write, valid while wr_en is high
  logic                  wr_en;
  logic [PHW-1:0]        wr_addr;
  logic [FLOW_WIDTH-1:0] wr_data;

  // One-cycle commit pulse
  logic                  commit_vld;
  logic [FW-1:0]         commit_flow;
  logic [SW-1:0]         commit_len;

  modport producer (output wr_en, wr_addr, wr_data, commit_vld, commit_flow, commit_len);
  modport buffer   (input  wr_en, wr_addr, wr_data, commit_vld, commit_flow, commit_len);
endinterface : mem_wr_if

// ----------------------------------------------------------
// Buffer to consumer transfers, credits flow back
// ----------------------------------------------------------
interface nfifo_credit_if #(
  parameter int FLOWS      = nfifo_dim_pkg::DEF_FLOWS,
  parameter int FLOW_WIDTH = nfifo_dim_pkg::DEF_FLOW_WIDTH
);
  localparam int FW = nfifo_addr_pkg::flow_width(FLOWS);

  logic                  xfer_vld;
  logic [FW-1:0]         xfer_flow;
  logic [FLOW_WIDTH-1:0] xfer_data;
  // One pulse per word popped by a reader
  logic [FLOWS-1:0]      credit_ret;

  modport sender   (output xfer_vld, xfer_flow, xfer_data, input  credit_ret);
  modport receiver (input  xfer_vld, xfer_flow, xfer_data, output credit_ret);
endinterface : nfifo_credit_if

`default_nettype wire

/* design/nfifo_read_port.sv */
`timescale 1ns/1ps
`default_nettype none

module nfifo_read_port #(
  parameter int FLOWS      = nfifo_dim_pkg::DEF_FLOWS,
  parameter int FLOW_WIDTH = nfifo_dim_pkg::DEF_FLOW_WIDTH,
  parameter int CREDITS    = nfifo_dim_pkg::DEF_CREDITS
) (
  input  logic                                clk,
  input  logic                                rst_n,
  nfifo_credit_if.receiver                    xfer,
  input  logic [FLOWS-1:0]                    read,
  output logic [FLOWS-1:0][FLOW_WIDTH-1:0]    data_out,
  output logic [FLOWS-1:0]                    data_vld,
  output logic [FLOWS-1:0]                    empty
);
  localparam int FW = nfifo_addr_pkg::flow_width(FLOWS);
  localparam int QW = (CREDITS > 1) ? $clog2(CREDITS) : 1;
  localparam int CW = $clog2(CREDITS + 1);

  // Small FIFO per flow, sized by the credits
  logic [FLOW_WIDTH-1:0] fifo_q [FLOWS][CREDITS];
  logic [QW-1:0]         wr_ptr [FLOWS];
  logic [QW-1:0]         rd_ptr [FLOWS];
  logic [CW-1:0]         cnt    [FLOWS];
  logic [FLOWS-1:0]      push;
  logic [FLOWS-1:0]      pop;
  logic [FLOWS-1:0]      pop_q;

  function automatic logic [QW-1:0] next_ptr(input logic [QW-1:0] p);
    return (p == QW'(CREDITS - 1)) ? '0 : p + 1'b1;
  endfunction

  always_comb begin
    for (int f = 0; f < FLOWS; f++) begin
      push[f]  = xfer.xfer_vld && (xfer.xfer_flow == FW'(f));
      empty[f] = (cnt[f] == '0);
      // Read while empty is dropped
      pop[f]   = read[f] && !empty[f];
    end
  end

  // ----------------------------------------------------------
  // FIFO control
  // ----------------------------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int f = 0; f < FLOWS; f++) begin
        wr_ptr[f] <= '0;
        rd_ptr[f] <= '0;
        cnt[f]    <= '0;
      end
      pop_q <= '0;
    end else begin
      pop_q <= pop;
      for (int f = 0; f < FLOWS; f++) begin
        if (push[f]) begin
          wr_ptr[f] <= next_ptr(wr_ptr[f]);
        end
        if (pop[f]) begin
          rd_ptr[f] <= next_ptr(rd_ptr[f]);
        end
        // No overflow, the sender holds a credit per free slot
        cnt[f] <= cnt[f] + CW'(push[f]) - CW'(pop[f]);
      end
    end
  end

  // Storage and output lanes
  always_ff @(posedge clk) begin
    for (int f = 0; f < FLOWS; f++) begin
      if (push[f]) begin
        fifo_q[f][wr_ptr[f]] <= xfer.xfer_data;
      end
      if (pop[f]) begin
        data_out[f] <= fifo_q[f][rd_ptr[f]];
      end
    end
  end

  // Valid and credit return share the pop pulse
  assign data_vld        = pop_q;
  assign xfer.credit_ret = pop_q;

endmodule : nfifo_read_port

`default_nettype wire

/* design/nfifo_write_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module nfifo_write_ctrl #(
  parameter int FLOWS      = nfifo_dim_pkg::DEF_FLOWS,
  parameter int FLOW_WIDTH = nfifo_dim_pkg::DEF_FLOW_WIDTH,
  parameter int BLOCK_SIZE = nfifo_dim_pkg::DEF_BLOCK_SIZE
) (
  input  logic                                             clk,
  input  logic                                             rst_n,
  input  logic [FLOW_WIDTH-1:0]                            data_in,
  input  logic [nfifo_addr_pkg::flow_width(FLOWS)-1:0]     block_addr,
  input  logic [nfifo_addr_pkg::ptr_width(BLOCK_SIZE)-1:0] wr_addr,
  input  logic                                             write,
  input  logic [nfifo_addr_pkg::status_width(BLOCK_SIZE)-1:0] new_len,
  input  logic                                             new_len_dv,
  mem_wr_if.producer                                       mem
);
  localparam int PW   = nfifo_addr_pkg::ptr_width(BLOCK_SIZE);
  localparam int SW   = nfifo_addr_pkg::status_width(BLOCK_SIZE);
  localparam int FW   = nfifo_addr_pkg::flow_width(FLOWS);
  localparam int PHW  = nfifo_addr_pkg::phys_width(FLOWS, BLOCK_SIZE);
  // One spare bit, sums stay below twice the block size
  localparam int SUMW = SW + 1;

  // Start of uncommitted space per flow
  logic [PW-1:0]         commit_ptr [FLOWS];
  logic [SUMW-1:0]       wr_sum;
  logic [SUMW-1:0]       len_sum;
  logic [PW-1:0]         wr_off;
  logic [PW-1:0]         next_ptr;
  logic [PHW-1:0]        phys_addr;

  // Output stage
  logic                  wr_en_q;
  logic [PHW-1:0]        wr_addr_q;
  logic [FLOW_WIDTH-1:0] wr_data_q;
  logic                  commit_vld_q;
  logic [FW-1:0]         commit_flow_q;
  logic [SW-1:0]         commit_len_q;

  // ----------------------------------------------------------
  // Address translation
  // ----------------------------------------------------------
  always_comb begin
    // Offset is relative to the commit point, wraps inside the block
    wr_sum = SUMW'(commit_ptr[block_addr]) + SUMW'(wr_addr);
    if (wr_sum >= SUMW'(BLOCK_SIZE)) begin
      wr_off = PW'(wr_sum - SUMW'(BLOCK_SIZE));
    end else begin
      wr_off = PW'(wr_sum);
    end
    phys_addr = PHW'(nfifo_addr_pkg::block_base(int'(block_addr), BLOCK_SIZE)) + PHW'(wr_off);

    // Commit point after new_len words
    len_sum = SUMW'(commit_ptr[block_addr]) + SUMW'(new_len);
    if (len_sum >= SUMW'(BLOCK_SIZE)) begin
      next_ptr = PW'(len_sum - SUMW'(BLOCK_SIZE));
    end else begin
      next_ptr = PW'(len_sum);
    end
  end

  // Control registers
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int f = 0; f < FLOWS; f++) begin
        commit_ptr[f] <= '0;
      end
      wr_en_q      <= 1'b0;
      commit_vld_q <= 1'b0;
    end else begin
      wr_en_q      <= write;
      commit_vld_q <= new_len_dv;
      // Write above used the old pointer, so the commit covers it
      if (new_len_dv) begin
        commit_ptr[block_addr] <= next_ptr;
      end
    end
  end

  // Payload, only sampled when qualified
  always_ff @(posedge clk) begin
    if (write) begin
      wr_addr_q <= phys_addr;
      wr_data_q <= data_in;
    end
    if (new_len_dv) begin
      commit_flow_q <= block_addr;
      commit_len_q  <= new_len;
    end
  end

  assign mem.wr_en       = wr_en_q;
  assign mem.wr_addr     = wr_addr_q;
  assign mem.wr_data     = wr_data_q;
  assign mem.commit_vld  = commit_vld_q;
  assign mem.commit_flow = commit_flow_q;
  assign mem.commit_len  = commit_len_q;

endmodule : nfifo_write_ctrl

`default_nettype wire

/* mem2nfifo.f */
design/nfifo_dim_pkg.sv
design/nfifo_addr_pkg.sv
design/nfifo_if.sv
design/nfifo_write_ctrl.sv
design/nfifo_block_mem.sv
design/nfifo_read_port.sv
design/mem2nfifo.sv
tb/mem2nfifo_assert.sv
tb/tb_mem2nfifo.sv

/* tb/mem2nfifo_assert.sv */
`timescale 1ns/1ps
`default_nettype none

// ----------------------------------------------------------
// Reader handshake and status checks on the top level
// ----------------------------------------------------------
module mem2nfifo_assert #(
  parameter int FLOWS      = nfifo_dim_pkg::DEF_FLOWS,
  parameter int BLOCK_SIZE = nfifo_dim_pkg::DEF_BLOCK_SIZE
) (
  input  logic                                                        clk,
  input  logic                                                        rst_n,
  input  logic [FLOWS-1:0]                                            read,
  input  logic [FLOWS-1:0]                                            empty,
  input  logic [FLOWS-1:0]                                            data_vld,
  input  logic [FLOWS-1:0]                                            full,
  input  logic [FLOWS-1:0][nfifo_addr_pkg::status_width(BLOCK_SIZE)-1:0] status
);
  localparam int SW = nfifo_addr_pkg::status_width(BLOCK_SIZE);

  // Assertion failures so far
  int fail_cnt = 0;

  // Outputs held at reset values while reset is asserted
  a_reset_values: assert property (@(posedge clk)
    !rst_n |-> (empty == {FLOWS{1'b1}}) && (data_vld == '0))
    else begin
      $error("empty or data_vld left reset values during reset");
      fail_cnt++;
    end

  for (genvar f = 0; f < FLOWS; f++) begin : g_flow
    // Valid word only after an accepted read
    a_vld_after_read: assert property (@(posedge clk) disable iff (!rst_n)
      data_vld[f] |-> $past(read[f] && !empty[f]))
      else begin
        $error("data_vld on flow %0d without an accepted read", f);
        fail_cnt++;
      end

    // Full flag tracks the occupancy
    a_full_status: assert property (@(posedge clk) disable iff (!rst_n)
      full[f] == (status[f] == SW'(BLOCK_SIZE)))
      else begin
        $error("full on flow %0d disagrees with status", f);
        fail_cnt++;
      end
  end

endmodule : mem2nfifo_assert

`default_nettype wire

/* tb/tb_mem2nfifo.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_mem2nfifo;
  localparam int FLOWS      = nfifo_dim_pkg::DEF_FLOWS;
  localparam int FLOW_WIDTH = nfifo_dim_pkg::DEF_FLOW_WIDTH;
  localparam int BLOCK_SIZE = nfifo_dim_pkg::DEF_BLOCK_SIZE;
  localparam int FW = nfifo_addr_pkg::flow_width(FLOWS);
  localparam int PW = nfifo_addr_pkg::ptr_width(BLOCK_SIZE);
  localparam int SW = nfifo_addr_pkg::status_width(BLOCK_SIZE);

  logic                             clk;
  logic                             rst_n;
  logic [FLOW_WIDTH-1:0]            data_in;
  logic [FW-1:0]                    block_addr;
  logic [PW-1:0]                    wr_addr;
  logic                             write;
  logic [SW-1:0]                    new_len;
  logic                             new_len_dv;
  logic [FLOWS-1:0]                 full;
  logic [FLOWS-1:0][SW-1:0]         status;
  logic [FLOWS-1:0][FLOW_WIDTH-1:0] data_out;
  logic [FLOWS-1:0]                 data_vld;
  logic [FLOWS-1:0]                 read;
  logic [FLOWS-1:0]                 empty;

  // Reference model, committed words in delivery order
  logic [FLOW_WIDTH-1:0] model_q [FLOWS][$];
  int                    model_occ [FLOWS];
  logic [FLOWS-1:0]      acc_prev;
  logic [FLOWS-1:0]      stall_mask;
  logic                  reading;
  int                    mismatches;
  int                    timeouts;
  int                    sf;

  mem2nfifo u_mem2nfifo (
    .clk (clk), .rst_n (rst_n), .data_in (data_in), .block_addr (block_addr),
    .wr_addr (wr_addr), .write (write), .new_len (new_len), .new_len_dv (new_len_dv),
    .full (full), .status (status), .data_out (data_out), .data_vld (data_vld),
    .read (read), .empty (empty)
  );

  bind mem2nfifo mem2nfifo_assert #(.FLOWS(FLOWS), .BLOCK_SIZE(BLOCK_SIZE)) u_assert (
    .clk (clk), .rst_n (rst_n), .read (read), .empty (empty),
    .data_vld (data_vld), .full (full), .status (status)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic check_eq(input logic [31:0] actual, input logic [31:0] expected,
                          input string msg);
    if (actual !== expected) begin
      mismatches++;
      $display("[FAIL] %0t ns %s: got %0h, expected %0h", $time, msg, actual, expected);
    end
  endtask

  // Random reader, stalled flows masked off
  always @(posedge clk) begin
    if (reading) begin
      read <= FLOWS'($urandom) & ~stall_mask;
    end else begin
      read <= '0;
    end
  end

  // ----------------------------------------------------------
  // Output monitor
  // ----------------------------------------------------------
  always @(posedge clk) begin
    logic [FLOW_WIDTH-1:0] exp_word;
    if (!rst_n) begin
      acc_prev = '0;
    end else begin
      for (int f = 0; f < FLOWS; f++) begin
        // One cycle after the accepted read, never otherwise
        check_eq(data_vld[f], acc_prev[f], $sformatf("flow %0d data_vld timing", f));
        if (data_vld[f]) begin
          if (model_q[f].size() == 0) begin
            mismatches++;
            $display("%0t ns flow %0d delivered a word that was never committed", $time, f);
          end else begin
            exp_word = model_q[f].pop_front();
            check_eq(data_out[f], exp_word, $sformatf("flow %0d data_out", f));
            model_occ[f]--;
          end
        end
      end
      acc_prev = read & ~empty;
    end
  end

  // Shuffled offsets of one flow, commit on the last write
  task automatic write_batch(input int flow);
    int free;
    int n;
    int j;
    int tmp;
    int offs [BLOCK_SIZE];
    logic [FLOW_WIDTH-1:0] words [BLOCK_SIZE];
    @(negedge clk);
    free = BLOCK_SIZE - model_occ[flow];
    if (free == 0) begin
      return;
    end
    n = 1 + int'($urandom % free);
    for (int k = 0; k < n; k++) begin
      offs[k]  = k;
      words[k] = FLOW_WIDTH'($urandom);
    end
    for (int k = n - 1; k > 0; k--) begin
      j = int'($urandom % (k + 1));
      tmp = offs[k];
      offs[k] = offs[j];
      offs[j] = tmp;
    end
    for (int k = 0; k < n; k++) begin
      @(posedge clk);
      write      <= 1'b1;
      block_addr <= FW'(flow);
      wr_addr    <= PW'(offs[k]);
      data_in    <= words[offs[k]];
      if (k == n - 1) begin
        new_len_dv <= 1'b1;
        new_len    <= SW'(n);
      end
    end
    // Delivery follows offset order
    @(negedge clk);
    for (int k = 0; k < n; k++) begin
      model_q[flow].push_back(words[k]);
    end
    model_occ[flow] += n;
    @(posedge clk);
    write      <= 1'b0;
    new_len_dv <= 1'b0;
  endtask

  // Readers off, sender settles, then status against model
  task automatic idle_check(input int cycles);
    @(negedge clk);
    reading = 1'b0;
    repeat (cycles) @(negedge clk);
    for (int f = 0; f < FLOWS; f++) begin
      check_eq(status[f], model_occ[f], $sformatf("flow %0d idle status", f));
      check_eq(empty[f], model_occ[f] == 0, $sformatf("flow %0d idle empty", f));
      check_eq(full[f], model_occ[f] == BLOCK_SIZE, $sformatf("flow %0d idle full", f));
    end
  endtask

  task automatic wait_full(input int flow, input logic level);
    int i;
    @(negedge clk);
    for (i = 0; i < 300 && full[flow] !== level; i++) begin
      @(negedge clk);
    end
    if (full[flow] !== level) begin
      timeouts++;
      $display("%0t ns timeout waiting for full[%0d] to become %0b", $time, flow, level);
    end
  endtask

  task automatic wait_drained();
    int i;
    int left;
    left = 1;
    for (i = 0; i < 3000 && left != 0; i++) begin
      @(negedge clk);
      left = 0;
      for (int f = 0; f < FLOWS; f++) begin
        left += model_q[f].size();
      end
    end
    if (left != 0) begin
      timeouts++;
      $display("%0t ns timeout, %0d committed words never came out", $time, left);
    end
  endtask

  // ----------------------------------------------------------
  // Test sequence
  // ----------------------------------------------------------
  initial begin
    void'($urandom(32'hc9b5));
    rst_n      = 1'b0;
    data_in    = '0;
    block_addr = '0;
    wr_addr    = '0;
    write      = 1'b0;
    new_len    = '0;
    new_len_dv = 1'b0;
    read       = '0;
    reading    = 1'b0;
    stall_mask = '0;
    mismatches = 0;
    timeouts   = 0;
    for (int f = 0; f < FLOWS; f++) begin
      model_occ[f] = 0;
    end
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;

    // Quiet outputs before the first commit
    repeat (4) begin
      @(negedge clk);
      check_eq(empty, {FLOWS{1'b1}}, "empty after reset");
      check_eq(data_vld, '0, "data_vld after reset");
      check_eq(full, '0, "full after reset");
      check_eq(status, '0, "status after reset");
    end

    // Mixed traffic on all flows
    @(negedge clk);
    reading = 1'b1;
    repeat (60) begin
      write_batch(int'($urandom % FLOWS));
      repeat ($urandom % 4) @(posedge clk);
    end
    idle_check(12);

    // One reader stalled, the rest keep draining
    sf = int'($urandom % FLOWS);
    @(negedge clk);
    stall_mask = FLOWS'(1) << sf;
    reading    = 1'b1;
    repeat (20) begin
      write_batch(sf);
      write_batch((sf + 1 + int'($urandom % (FLOWS - 1))) % FLOWS);
    end
    wait_full(sf, 1'b1);
    check_eq(status[sf], BLOCK_SIZE, "stalled flow status");

    // Resume, everything drains in order
    @(negedge clk);
    stall_mask = '0;
    wait_drained();
    wait_full(sf, 1'b0);
    idle_check(12);

    $display("Checks done: %0d mismatches, %0d timeouts, %0d assertion failures",
             mismatches, timeouts, u_mem2nfifo.u_assert.fail_cnt);
    if (mismatches == 0 && timeouts == 0 && u_mem2nfifo.u_assert.fail_cnt == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule : tb_mem2nfifo

`default_nettype wire
